/* design/mipsPkg.sv */
`default_nettype none

package mipsPkg;

	typedef logic [31:0] wordT;
	typedef logic [4:0] regAddrT;
	typedef logic [3:0] byteEnT;
	typedef logic [3:0] aluOpT;
	typedef logic [1:0] wbSelT;
	typedef logic [1:0] fwdSelT;

	localparam aluOpT aluAdd = 4'd0;
	localparam aluOpT aluSub = 4'd1;
	localparam aluOpT aluAnd = 4'd2;
	localparam aluOpT aluOr = 4'd3;
	localparam aluOpT aluXor = 4'd4;
	localparam aluOpT aluSlt = 4'd5;
	localparam aluOpT aluSltu = 4'd6;
	localparam aluOpT aluSll = 4'd7;
	localparam aluOpT aluLui = 4'd8;

	localparam wbSelT wbAlu = 2'd0;
	localparam wbSelT wbLoad = 2'd1;
	localparam wbSelT wbLink = 2'd2;

	localparam fwdSelT fwdRf = 2'd0;
	localparam fwdSelT fwdMem = 2'd1;
	localparam fwdSelT fwdWb = 2'd2;

	typedef struct packed {
		wordT pc;
		wordT instr;
		logic valid;
	} ifIdT;

	typedef struct packed {
		aluOpT aluOp;
		logic useImm;
		logic rfWen;
		logic memRead;
		logic memWrite;
		logic byteAccess;
		wbSelT wbSel;
	} ctrlT;

	typedef struct packed {
		ctrlT ctrl;
		wordT pc;
		regAddrT rs;
		regAddrT rt;
		regAddrT dest;
		wordT rsVal;
		wordT rtVal;
		wordT imm;
		logic [4:0] shamt;
	} idExT;

	typedef struct packed {
		logic rfWen;
		logic memRead;
		logic byteAccess;
		wbSelT wbSel;
		wordT pc;
		regAddrT dest;
		wordT aluResult;
		logic [1:0] byteOffset;
	} exMemT;

	typedef struct packed {
		logic rfWen;
		wordT pc;
		regAddrT dest;
		wordT wdata;
	} memWbT;

	// operand source shared by the decode comparator and the execute stage
	function automatic wordT fwdMux(fwdSelT sel, wordT rfVal, wordT memVal, wordT wbVal);
		case (sel)
			fwdMem: return memVal;
			fwdWb: return wbVal;
			default: return rfVal;
		endcase
	endfunction

endpackage

`default_nettype wire

/* design/regFile.sv */
`timescale 1ns/1ps
`default_nettype none

module regFile import mipsPkg::*; (
	input wire logic clk,
	input wire logic reset,
	input wire regAddrT rsAddr,
	input wire regAddrT rtAddr,
	input wire memWbT memWb,
	output wordT rsVal,
	output wordT rtVal
);

	wordT regs [32];

	// register 0 is never written, so it keeps the zero from reset
	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (memWb.rfWen && memWb.dest != 5'd0) begin
			regs[memWb.dest] <= memWb.wdata;
		end
	end

	// a write in the same cycle is seen by the read
	function automatic wordT readPort(regAddrT addr);
		if (memWb.rfWen && memWb.dest == addr && addr != 5'd0) begin
			return memWb.wdata;
		end
		return regs[addr];
	endfunction

	always_comb begin
		rsVal = readPort(rsAddr);
		rtVal = readPort(rtAddr);
	end

endmodule

`default_nettype wire

/* design/hazardUnit.sv */
`timescale 1ns/1ps
`default_nettype none

module hazardUnit import mipsPkg::*; (
	input wire regAddrT rsAddr,
	input wire regAddrT rtAddr,
	input wire logic usesRs,
	input wire logic usesRt,
	input wire logic isBranch,
	input wire idExT idEx,
	input wire exMemT exMem,
	input wire memWbT memWb,
	output logic stall,
	output fwdSelT fwdRsEx,
	output fwdSelT fwdRtEx,
	output fwdSelT fwdRsId,
	output fwdSelT fwdRtId
);

	logic exMatch;
	logic memLoadMatch;

	// youngest older producer wins, loads in MEM have no data yet
	function automatic fwdSelT pickSource(regAddrT src, exMemT mem, memWbT wb);
		if (mem.rfWen && !mem.memRead && mem.dest == src) begin
			return fwdMem;
		end
		if (wb.rfWen && wb.dest == src) begin
			return fwdWb;
		end
		return fwdRf;
	endfunction

	assign fwdRsEx = pickSource(idEx.rs, exMem, memWb);
	assign fwdRtEx = pickSource(idEx.rt, exMem, memWb);
	assign fwdRsId = pickSource(rsAddr, exMem, memWb);
	assign fwdRtId = pickSource(rtAddr, exMem, memWb);

	assign exMatch = idEx.ctrl.rfWen
		&& ((usesRs && idEx.dest == rsAddr) || (usesRt && idEx.dest == rtAddr));
	assign memLoadMatch = exMem.rfWen && exMem.memRead
		&& ((usesRs && exMem.dest == rsAddr) || (usesRt && exMem.dest == rtAddr));

	// a load in EX blocks any consumer, a branch also waits on ALU results in EX
	assign stall = (exMatch && (idEx.ctrl.memRead || isBranch)) || (memLoadMatch && isBranch);

endmodule

`default_nettype wire

/* design/fetchStage.sv */
`timescale 1ns/1ps
`default_nettype none

module fetchStage import mipsPkg::*; #(
	parameter wordT resetPc = 32'hBFC00000
) (
	input wire logic clk,
	input wire logic reset,
	input wire logic stall,
	input wire logic branchTaken,
	input wire wordT branchTarget,
	input wire wordT instSramRdata,
	output logic instSramEn,
	output wordT instSramAddr,
	output ifIdT ifId
);

	logic started;
	logic validReg;
	logic redirectValid;
	wordT redirectPc;
	wordT pcReg;
	wordT nextPc;

	// the branch in decode fetches its delay slot now, the target goes out next
	assign nextPc = redirectValid ? redirectPc : pcReg + 32'd4;
	assign instSramEn = started && !stall;
	assign instSramAddr = nextPc;

	// the SRAM output register doubles as the instruction half of IF/ID
	assign ifId = '{pc: pcReg, instr: instSramRdata, valid: validReg};

	always_ff @(posedge clk) begin
		if (reset) begin
			started <= 1'b0;
			validReg <= 1'b0;
			redirectValid <= 1'b0;
			pcReg <= resetPc - 32'd4;
		end else begin
			started <= 1'b1;
			if (!stall) begin
				validReg <= started;
			end
			if (instSramEn) begin
				pcReg <= nextPc;
				redirectValid <= 1'b0;
			end
			if (branchTaken && !stall) begin
				redirectValid <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (branchTaken && !stall) begin
			redirectPc <= branchTarget;
		end
	end

endmodule

`default_nettype wire

/* design/decodeStage.sv */
`timescale 1ns/1ps
`default_nettype none

module decodeStage import mipsPkg::*; (
	input wire logic clk,
	input wire logic reset,
	input wire logic stall,
	input wire ifIdT ifId,
	input wire wordT rsVal,
	input wire wordT rtVal,
	input wire exMemT exMem,
	input wire memWbT memWb,
	input wire fwdSelT fwdRsId,
	input wire fwdSelT fwdRtId,
	output regAddrT rsAddr,
	output regAddrT rtAddr,
	output logic usesRs,
	output logic usesRt,
	output logic isBranch,
	output logic branchTaken,
	output wordT branchTarget,
	output idExT idEx
);

	localparam logic [5:0] opSpecial = 6'h00;
	localparam logic [5:0] opJ = 6'h02;
	localparam logic [5:0] opJal = 6'h03;
	localparam logic [5:0] opBeq = 6'h04;
	localparam logic [5:0] opBne = 6'h05;
	localparam logic [5:0] opAddiu = 6'h09;
	localparam logic [5:0] opSlti = 6'h0A;
	localparam logic [5:0] opAndi = 6'h0C;
	localparam logic [5:0] opOri = 6'h0D;
	localparam logic [5:0] opXori = 6'h0E;
	localparam logic [5:0] opLui = 6'h0F;
	localparam logic [5:0] opLw = 6'h23;
	localparam logic [5:0] opLbu = 6'h24;
	localparam logic [5:0] opSb = 6'h28;
	localparam logic [5:0] opSw = 6'h2B;

	localparam logic [5:0] fnSll = 6'h00;
	localparam logic [5:0] fnAddu = 6'h21;
	localparam logic [5:0] fnSubu = 6'h23;
	localparam logic [5:0] fnAnd = 6'h24;
	localparam logic [5:0] fnOr = 6'h25;
	localparam logic [5:0] fnXor = 6'h26;
	localparam logic [5:0] fnSlt = 6'h2A;
	localparam logic [5:0] fnSltu = 6'h2B;

	wordT instr;
	ctrlT ctrl;
	regAddrT dest;
	logic signExt;
	logic branchEq;
	logic branchNe;
	logic jump;
	wordT imm;
	wordT rsFwd;
	wordT rtFwd;
	wordT pcPlus4;
	idExT idExNext;

	assign instr = ifId.instr;
	assign rsAddr = instr[25:21];
	assign rtAddr = instr[20:16];

	always_comb begin
		ctrl = '0;
		ctrl.aluOp = aluAdd;
		ctrl.wbSel = wbAlu;
		dest = instr[20:16];
		signExt = 1'b1;
		usesRs = 1'b0;
		usesRt = 1'b0;
		branchEq = 1'b0;
		branchNe = 1'b0;
		jump = 1'b0;
		if (ifId.valid) begin
			case (instr[31:26])
				opSpecial: begin
					dest = instr[15:11];
					ctrl.rfWen = 1'b1;
					usesRs = 1'b1;
					usesRt = 1'b1;
					case (instr[5:0])
						fnAddu: ctrl.aluOp = aluAdd;
						fnSubu: ctrl.aluOp = aluSub;
						fnAnd: ctrl.aluOp = aluAnd;
						fnOr: ctrl.aluOp = aluOr;
						fnXor: ctrl.aluOp = aluXor;
						fnSlt: ctrl.aluOp = aluSlt;
						fnSltu: ctrl.aluOp = aluSltu;
						fnSll: begin
							ctrl.aluOp = aluSll;
							usesRs = 1'b0;
						end
						default: begin
							ctrl.rfWen = 1'b0;
							usesRs = 1'b0;
							usesRt = 1'b0;
						end
					endcase
				end
				opAddiu, opSlti, opAndi, opOri, opXori, opLui: begin
					ctrl.useImm = 1'b1;
					ctrl.rfWen = 1'b1;
					usesRs = instr[31:26] != opLui;
					signExt = instr[31:26] == opAddiu || instr[31:26] == opSlti;
					case (instr[31:26])
						opSlti: ctrl.aluOp = aluSlt;
						opAndi: ctrl.aluOp = aluAnd;
						opOri: ctrl.aluOp = aluOr;
						opXori: ctrl.aluOp = aluXor;
						opLui: ctrl.aluOp = aluLui;
						default: ctrl.aluOp = aluAdd;
					endcase
				end
				opLw, opLbu: begin
					ctrl.useImm = 1'b1;
					ctrl.rfWen = 1'b1;
					ctrl.memRead = 1'b1;
					ctrl.byteAccess = instr[31:26] == opLbu;
					ctrl.wbSel = wbLoad;
					usesRs = 1'b1;
				end
				opSw, opSb: begin
					ctrl.useImm = 1'b1;
					ctrl.memWrite = 1'b1;
					ctrl.byteAccess = instr[31:26] == opSb;
					usesRs = 1'b1;
					usesRt = 1'b1;
				end
				opBeq, opBne: begin
					branchEq = instr[31:26] == opBeq;
					branchNe = instr[31:26] == opBne;
					usesRs = 1'b1;
					usesRt = 1'b1;
				end
				opJ: jump = 1'b1;
				opJal: begin
					jump = 1'b1;
					ctrl.rfWen = 1'b1;
					ctrl.wbSel = wbLink;
					dest = 5'd31;
				end
				default: ;
			endcase
		end
		if (dest == 5'd0) begin
			ctrl.rfWen = 1'b0;
		end
	end

	assign imm = signExt ? {{16{instr[15]}}, instr[15:0]} : {16'h0000, instr[15:0]};

	// the comparator sees values from MEM and WB, never from a load still in flight
	assign rsFwd = fwdMux(fwdRsId, rsVal, exMem.aluResult, memWb.wdata);
	assign rtFwd = fwdMux(fwdRtId, rtVal, exMem.aluResult, memWb.wdata);

	assign pcPlus4 = ifId.pc + 32'd4;
	assign isBranch = branchEq || branchNe;
	assign branchTaken = jump || (branchEq && rsFwd == rtFwd) || (branchNe && rsFwd != rtFwd);
	assign branchTarget = jump ? {pcPlus4[31:28], instr[25:0], 2'b00}
		: pcPlus4 + {imm[29:0], 2'b00};

	always_comb begin
		idExNext.ctrl = stall ? ctrlT'('0) : ctrl;
		idExNext.pc = ifId.pc;
		idExNext.rs = rsAddr;
		idExNext.rt = rtAddr;
		idExNext.dest = dest;
		idExNext.rsVal = rsFwd;
		idExNext.rtVal = rtFwd;
		idExNext.imm = imm;
		idExNext.shamt = instr[10:6];
	end

	always_ff @(posedge clk) begin
		idEx <= idExNext;
		if (reset) begin
			idEx.ctrl <= '0;
		end
	end

endmodule

`default_nettype wire

/* design/executeStage.sv */
`timescale 1ns/1ps
`default_nettype none

module executeStage import mipsPkg::*; (
	input wire logic clk,
	input wire logic reset,
	input wire idExT idEx,
	input wire fwdSelT fwdRsEx,
	input wire fwdSelT fwdRtEx,
	input wire exMemT exMem,
	input wire memWbT memWb,
	output logic dataSramEn,
	output byteEnT dataSramWen,
	output wordT dataSramAddr,
	output wordT dataSramWdata,
	output exMemT exMemOut
);

	wordT opA;
	wordT storeVal;
	wordT opB;
	wordT aluOut;
	exMemT exMemNext;

	assign opA = fwdMux(fwdRsEx, idEx.rsVal, exMem.aluResult, memWb.wdata);
	assign storeVal = fwdMux(fwdRtEx, idEx.rtVal, exMem.aluResult, memWb.wdata);
	assign opB = idEx.ctrl.useImm ? idEx.imm : storeVal;

	always_comb begin
		case (idEx.ctrl.aluOp)
			aluSub: aluOut = opA - opB;
			aluAnd: aluOut = opA & opB;
			aluOr: aluOut = opA | opB;
			aluXor: aluOut = opA ^ opB;
			aluSlt: aluOut = wordT'($signed(opA) < $signed(opB));
			aluSltu: aluOut = wordT'(opA < opB);
			aluSll: aluOut = opB << idEx.shamt;
			aluLui: aluOut = {opB[15:0], 16'h0000};
			default: aluOut = opA + opB;
		endcase
	end

	assign dataSramEn = idEx.ctrl.memRead || idEx.ctrl.memWrite;
	assign dataSramAddr = {aluOut[31:2], 2'b00};

	// sb puts the byte on every lane and lets the enable pick one
	always_comb begin
		dataSramWen = 4'b0000;
		if (idEx.ctrl.memWrite) begin
			dataSramWen = idEx.ctrl.byteAccess ? byteEnT'(4'b0001 << aluOut[1:0]) : 4'b1111;
		end
	end
	assign dataSramWdata = idEx.ctrl.byteAccess ? {4{storeVal[7:0]}} : storeVal;

	always_comb begin
		exMemNext.rfWen = idEx.ctrl.rfWen;
		exMemNext.memRead = idEx.ctrl.memRead;
		exMemNext.byteAccess = idEx.ctrl.byteAccess;
		exMemNext.wbSel = idEx.ctrl.wbSel;
		exMemNext.pc = idEx.pc;
		exMemNext.dest = idEx.dest;
		// link address past the delay slot
		exMemNext.aluResult = idEx.ctrl.wbSel == wbLink ? idEx.pc + 32'd8 : aluOut;
		exMemNext.byteOffset = aluOut[1:0];
	end

	always_ff @(posedge clk) begin
		exMemOut <= exMemNext;
		if (reset) begin
			exMemOut.rfWen <= 1'b0;
			exMemOut.memRead <= 1'b0;
		end
	end

endmodule

`default_nettype wire

/* design/memoryStage.sv */
`timescale 1ns/1ps
`default_nettype none

module memoryStage import mipsPkg::*; (
	input wire logic clk,
	input wire logic reset,
	input wire exMemT exMem,
	input wire wordT dataSramRdata,
	output memWbT memWb,
	output wordT debugWbPc,
	output byteEnT debugWbRfWen,
	output regAddrT debugWbRfWnum,
	output wordT debugWbRfWdata
);

	logic [7:0] loadByte;
	wordT loadData;
	memWbT memWbNext;

	// read data arrives this cycle for the request made in execute
	assign loadByte = dataSramRdata[8 * exMem.byteOffset +: 8];
	assign loadData = exMem.byteAccess ? {24'h000000, loadByte} : dataSramRdata;

	always_comb begin
		memWbNext.rfWen = exMem.rfWen;
		memWbNext.pc = exMem.pc;
		memWbNext.dest = exMem.dest;
		memWbNext.wdata = exMem.wbSel == wbLoad ? loadData : exMem.aluResult;
	end

	always_ff @(posedge clk) begin
		memWb <= memWbNext;
		if (reset) begin
			memWb.rfWen <= 1'b0;
		end
	end

	assign debugWbPc = memWb.pc;
	assign debugWbRfWen = {4{memWb.rfWen}};
	assign debugWbRfWnum = memWb.dest;
	assign debugWbRfWdata = memWb.wdata;

endmodule

`default_nettype wire

/* design/mipsCore.sv */
`timescale 1ns/1ps
`default_nettype none

module mipsCore import mipsPkg::*; #(
	parameter wordT resetPc = 32'hBFC00000
) (
	input wire logic clk,
	input wire logic reset,
	output logic instSramEn,
	output wordT instSramAddr,
	input wire wordT instSramRdata,
	output logic dataSramEn,
	output byteEnT dataSramWen,
	output wordT dataSramAddr,
	output wordT dataSramWdata,
	input wire wordT dataSramRdata,
	output wordT debugWbPc,
	output byteEnT debugWbRfWen,
	output regAddrT debugWbRfWnum,
	output wordT debugWbRfWdata
);

	ifIdT ifId;
	idExT idEx;
	exMemT exMem;
	memWbT memWb;
	regAddrT rsAddr;
	regAddrT rtAddr;
	wordT rsVal;
	wordT rtVal;
	logic usesRs;
	logic usesRt;
	logic isBranch;
	logic branchTaken;
	wordT branchTarget;
	logic stall;
	fwdSelT fwdRsEx;
	fwdSelT fwdRtEx;
	fwdSelT fwdRsId;
	fwdSelT fwdRtId;

	fetchStage #(.resetPc(resetPc)) u_fetch (
		.clk(clk), .reset(reset), .stall(stall),
		.branchTaken(branchTaken), .branchTarget(branchTarget),
		.instSramRdata(instSramRdata), .instSramEn(instSramEn),
		.instSramAddr(instSramAddr), .ifId(ifId)
	);

	decodeStage u_decode (
		.clk(clk), .reset(reset), .stall(stall), .ifId(ifId),
		.rsVal(rsVal), .rtVal(rtVal), .exMem(exMem), .memWb(memWb),
		.fwdRsId(fwdRsId), .fwdRtId(fwdRtId), .rsAddr(rsAddr), .rtAddr(rtAddr),
		.usesRs(usesRs), .usesRt(usesRt), .isBranch(isBranch),
		.branchTaken(branchTaken), .branchTarget(branchTarget), .idEx(idEx)
	);

	regFile u_regFile (
		.clk(clk), .reset(reset), .rsAddr(rsAddr), .rtAddr(rtAddr),
		.memWb(memWb), .rsVal(rsVal), .rtVal(rtVal)
	);

	hazardUnit u_hazard (
		.rsAddr(rsAddr), .rtAddr(rtAddr), .usesRs(usesRs), .usesRt(usesRt),
		.isBranch(isBranch), .idEx(idEx), .exMem(exMem), .memWb(memWb),
		.stall(stall), .fwdRsEx(fwdRsEx), .fwdRtEx(fwdRtEx),
		.fwdRsId(fwdRsId), .fwdRtId(fwdRtId)
	);

	executeStage u_execute (
		.clk(clk), .reset(reset), .idEx(idEx), .fwdRsEx(fwdRsEx), .fwdRtEx(fwdRtEx),
		.exMem(exMem), .memWb(memWb), .dataSramEn(dataSramEn),
		.dataSramWen(dataSramWen), .dataSramAddr(dataSramAddr),
		.dataSramWdata(dataSramWdata), .exMemOut(exMem)
	);

	memoryStage u_memory (
		.clk(clk), .reset(reset), .exMem(exMem), .dataSramRdata(dataSramRdata),
		.memWb(memWb), .debugWbPc(debugWbPc), .debugWbRfWen(debugWbRfWen),
		.debugWbRfWnum(debugWbRfWnum), .debugWbRfWdata(debugWbRfWdata)
	);

endmodule

`default_nettype wire

/* testbench/mipsCoreAssert.sv */
`timescale 1ns/1ps
`default_nettype none

module mipsCoreAssert import mipsPkg::*; (
	input wire logic clk,
	input wire logic reset,
	input wire logic dataSramEn,
	input wire byteEnT dataSramWen,
	input wire byteEnT debugWbRfWen,
	input wire regAddrT debugWbRfWnum
);

	// byte enables only go out together with a data request
	wenWithEn: assert property (@(posedge clk) disable iff (reset)
		dataSramWen != 4'b0000 |-> dataSramEn)
		else $error("data SRAM write enable %b without a data request", dataSramWen);

	// one lane for sb, all four for sw
	lanePattern: assert property (@(posedge clk) disable iff (reset)
		dataSramWen != 4'b0000 |-> ($onehot(dataSramWen) || dataSramWen == 4'b1111))
		else $error("data SRAM write enable %b is not a legal lane pattern", dataSramWen);

	noZeroWrite: assert property (@(posedge clk) disable iff (reset)
		debugWbRfWen != 4'b0000 |-> debugWbRfWnum != 5'd0)
		else $error("debug port shows a write to register 0");

endmodule

bind mipsCore mipsCoreAssert u_assert (
	.clk(clk),
	.reset(reset),
	.dataSramEn(dataSramEn),
	.dataSramWen(dataSramWen),
	.debugWbRfWen(debugWbRfWen),
	.debugWbRfWnum(debugWbRfWnum)
);

`default_nettype wire

/* testbench/tbMipsCore.sv */
`timescale 1ns/1ps
`default_nettype none

module tbMipsCore import mipsPkg::*; ();

	localparam wordT resetPc = 32'hBFC00000;
	localparam int randomCount = 200;

	localparam int opSpecial = 'h00;
	localparam int opJ = 'h02;
	localparam int opJal = 'h03;
	localparam int opBeq = 'h04;
	localparam int opBne = 'h05;
	localparam int opAddiu = 'h09;
	localparam int opSlti = 'h0A;
	localparam int opAndi = 'h0C;
	localparam int opOri = 'h0D;
	localparam int opXori = 'h0E;
	localparam int opLui = 'h0F;
	localparam int opLw = 'h23;
	localparam int opLbu = 'h24;
	localparam int opSb = 'h28;
	localparam int opSw = 'h2B;
	localparam int fnSll = 'h00;
	localparam int fnAddu = 'h21;
	localparam int fnSubu = 'h23;
	localparam int fnAnd = 'h24;
	localparam int fnOr = 'h25;
	localparam int fnXor = 'h26;
	localparam int fnSlt = 'h2A;
	localparam int fnSltu = 'h2B;

	typedef struct packed {
		logic [2:0] sect;
		wordT pc;
		regAddrT num;
		wordT data;
	} wbT;

	logic clk;
	logic reset;
	logic instSramEn;
	wordT instSramAddr;
	wordT instSramRdata;
	logic dataSramEn;
	byteEnT dataSramWen;
	wordT dataSramAddr;
	wordT dataSramWdata;
	wordT dataSramRdata;
	wordT debugWbPc;
	byteEnT debugWbRfWen;
	regAddrT debugWbRfWnum;
	wordT debugWbRfWdata;

	wordT imem [1024];
	wordT dmem [256];
	wbT expected [$];
	wordT finalPc;
	int progLen;
	int sectStart [5];
	int sectChecks [5];
	int sectErrs [5];
	int nextReport;
	int checkCount;
	int errorCount;
	logic programReady = 1'b0;
	string sectName [5] = '{"reset", "alu", "memory", "branch", "random"};

	mipsCore #(.resetPc(resetPc)) u_dut (
		.clk(clk), .reset(reset),
		.instSramEn(instSramEn), .instSramAddr(instSramAddr), .instSramRdata(instSramRdata),
		.dataSramEn(dataSramEn), .dataSramWen(dataSramWen), .dataSramAddr(dataSramAddr),
		.dataSramWdata(dataSramWdata), .dataSramRdata(dataSramRdata),
		.debugWbPc(debugWbPc), .debugWbRfWen(debugWbRfWen),
		.debugWbRfWnum(debugWbRfWnum), .debugWbRfWdata(debugWbRfWdata)
	);

	initial begin
		clk = 1'b0;
		forever begin
			#50 clk = ~clk;
		end
	end

	initial begin
		reset = 1'b1;
		instSramRdata = '0;
		dataSramRdata = '0;
		repeat (8) @(posedge clk);
		reset <= 1'b0;
	end

	// both SRAMs keep their read data while the enable is low
	always @(posedge clk) begin
		if (instSramEn) begin
			instSramRdata <= imem[instSramAddr[11:2]];
		end
	end

	always @(posedge clk) begin
		if (dataSramEn) begin
			dataSramRdata <= dmem[dataSramAddr[9:2]];
			for (int i = 0; i < 4; i++) begin
				if (dataSramWen[i]) begin
					dmem[dataSramAddr[9:2]][8 * i +: 8] <= dataSramWdata[8 * i +: 8];
				end
			end
		end
	end

	function automatic wordT encR(int rs, int rt, int rd, int sh, int fn);
		return {6'h00, 5'(rs), 5'(rt), 5'(rd), 5'(sh), 6'(fn)};
	endfunction

	function automatic wordT encI(int op, int rs, int rt, int imm);
		return {6'(op), 5'(rs), 5'(rt), 16'(imm)};
	endfunction

	function automatic wordT pcOf(int idx);
		return resetPc + 32'(4 * idx);
	endfunction

	function automatic wordT fillWord(int idx);
		logic [7:0] a;
		a = 8'(idx);
		return {a ^ 8'h5A, ~a, a, a ^ 8'hC3};
	endfunction

	function automatic void emit(wordT instr);
		imem[progLen] = instr;
		progLen++;
	endfunction

	// skip counts the instructions passed over after the delay slot
	function automatic void emitBranch(int op, int rs, int rt, int skip);
		emit(encI(op, rs, rt, skip + 1));
	endfunction

	function automatic void emitJumpTo(int op, int targetIdx);
		wordT target;
		target = pcOf(targetIdx);
		emit({6'(op), target[27:2]});
	endfunction

	function automatic int sectionOf(wordT pc);
		int idx;
		int s;
		idx = int'((pc - resetPc) >> 2);
		s = 1;
		for (int k = 2; k < 5; k++) begin
			if (idx >= sectStart[k]) begin
				s = k;
			end
		end
		return s;
	endfunction

	function automatic void buildDirected();
		sectStart[1] = progLen;
		emit(encI(opLui, 0, 1, 'h1234));
		emit(encI(opOri, 1, 1, 'h5678));
		emit(encI(opAddiu, 1, 2, -1));
		emit(encR(1, 2, 3, 0, fnAddu));
		emit(encR(3, 1, 4, 0, fnSubu));
		emit(encR(4, 1, 5, 0, fnAnd));
		emit(encR(5, 2, 6, 0, fnOr));
		emit(encR(6, 3, 7, 0, fnXor));
		emit(encR(7, 1, 8, 0, fnSlt));
		emit(encR(1, 7, 9, 0, fnSltu));
		emit(encR(0, 9, 10, 4, fnSll));
		emit(encI(opSlti, 2, 11, -5));
		emit(encI(opAndi, 1, 12, 'hF0F0));
		emit(encI(opXori, 12, 13, 'hFFFF));
		emit(encR(1, 2, 0, 0, fnAddu));
		emit(encR(0, 13, 14, 0, fnAddu));
		sectStart[2] = progLen;
		emit(encI(opAddiu, 0, 20, 'h100));
		emit(encI(opSw, 20, 1, 0));
		emit(encI(opSb, 20, 13, 1));
		emit(encI(opLw, 20, 15, 0));
		emit(encI(opLbu, 20, 16, 1));
		emit(encR(16, 16, 17, 0, fnAddu));
		emit(encI(opLbu, 20, 18, 3));
		emit(encI(opLw, 20, 19, 4));
		emit(encR(19, 19, 19, 0, fnAddu));
		emit(encI(opSb, 20, 2, 6));
		emit(encI(opLbu, 20, 21, 6));
		emit(encI(opLw, 20, 22, 4));
		sectStart[3] = progLen;
		emit(encI(opAddiu, 0, 1, 5));
		emit(encI(opAddiu, 0, 2, 5));
		emitBranch(opBeq, 1, 2, 1);
		emit(encI(opAddiu, 0, 3, 1));
		emit(encI(opAddiu, 0, 3, 99));
		emit(encI(opAddiu, 3, 4, 7));
		emitBranch(opBne, 1, 2, 1);
		emit(encI(opAddiu, 0, 5, 2));
		emit(encI(opAddiu, 0, 6, 3));
		emit(encI(opLw, 0, 7, 'h100));
		emitBranch(opBne, 7, 0, 1);
		emit(encI(opAddiu, 0, 8, 4));
		emit(encI(opAddiu, 0, 8, 66));
		emitBranch(opBeq, 8, 0, 0);
		emit(encI(opAddiu, 0, 9, 9));
		emitJumpTo(opJal, progLen + 3);
		emit(encI(opAddiu, 0, 10, 10));
		emit(encI(opAddiu, 0, 10, 77));
		emit(encI(opAddiu, 31, 11, 0));
		emitJumpTo(opJ, progLen + 3);
		emit(encR(31, 11, 12, 0, fnAddu));
		emit(encI(opAddiu, 0, 12, 55));
		emit(encI(opAddiu, 12, 13, 1));
	endfunction

	task automatic buildRandom();
		int fnList [8];
		int opList [6];
		int kind;
		int rs;
		int rt;
		int rd;
		logic lastCtl;
		fnList = '{fnAddu, fnSubu, fnAnd, fnOr, fnXor, fnSlt, fnSltu, fnSll};
		opList = '{opAddiu, opSlti, opAndi, opOri, opXori, opLui};
		lastCtl = 1'b0;
		sectStart[4] = progLen;
		for (int i = 0; i < randomCount; i++) begin
			kind = $urandom % 20;
			rs = $urandom % 16;
			rt = $urandom % 16;
			rd = $urandom % 16;
			// no branch in a delay slot, and targets stay inside the section
			if (kind >= 18 && (lastCtl || i > randomCount - 8)) begin
				kind = kind - 10;
			end
			lastCtl = kind >= 18;
			if (kind < 7) begin
				emit(encR(rs, rt, rd, 0, fnList[kind]));
			end else if (kind == 7) begin
				emit(encR(0, rt, rd, $urandom % 32, fnSll));
			end else if (kind < 14) begin
				emit(encI(opList[kind - 8], rs, rd, $urandom % 65536));
			end else if (kind == 14) begin
				emit(encI(opLw, 0, rd, 4 * ($urandom % 256)));
			end else if (kind == 15) begin
				emit(encI(opLbu, 0, rd, $urandom % 1024));
			end else if (kind == 16) begin
				emit(encI(opSw, 0, rt, 4 * ($urandom % 256)));
			end else if (kind == 17) begin
				emit(encI(opSb, 0, rt, $urandom % 1024));
			end else if (kind == 18) begin
				emitBranch($urandom % 2 == 0 ? opBeq : opBne, rs, rt, $urandom % 4);
			end else begin
				emitJumpTo(opJal, progLen + 2 + $urandom % 4);
			end
		end
		finalPc = pcOf(progLen);
		emitJumpTo(opJ, progLen);
		emit('0);
	endtask

	// the instruction set model runs with delay slots and queues every register write
	function automatic void runInstrSet();
		wordT regs [32];
		wordT mem [256];
		wordT pc;
		wordT npc;
		wordT nextNpc;
		wordT instr;
		wordT a;
		wordT b;
		wordT se;
		wordT ze;
		wordT addr;
		wordT res;
		int op;
		int dest;
		int steps;
		for (int i = 0; i < 32; i++) begin
			regs[i] = '0;
		end
		for (int i = 0; i < 256; i++) begin
			mem[i] = fillWord(i);
		end
		pc = resetPc;
		npc = resetPc + 32'd4;
		steps = 0;
		while (pc != finalPc && steps < 10000) begin
			instr = imem[pc[11:2]];
			op = int'(instr[31:26]);
			a = regs[instr[25:21]];
			b = regs[instr[20:16]];
			se = {{16{instr[15]}}, instr[15:0]};
			ze = {16'h0000, instr[15:0]};
			addr = a + se;
			nextNpc = npc + 32'd4;
			res = '0;
			case (op)
				opSpecial: dest = int'(instr[15:11]);
				opAddiu, opSlti, opAndi, opOri, opXori, opLui, opLw, opLbu:
					dest = int'(instr[20:16]);
				opJal: dest = 31;
				default: dest = 0;
			endcase
			case (op)
				opSpecial: begin
					case (int'(instr[5:0]))
						fnAddu: res = a + b;
						fnSubu: res = a - b;
						fnAnd: res = a & b;
						fnOr: res = a | b;
						fnXor: res = a ^ b;
						fnSlt: res = wordT'($signed(a) < $signed(b));
						fnSltu: res = wordT'(a < b);
						fnSll: res = b << instr[10:6];
						default: dest = 0;
					endcase
				end
				opAddiu: res = a + se;
				opSlti: res = wordT'($signed(a) < $signed(se));
				opAndi: res = a & ze;
				opOri: res = a | ze;
				opXori: res = a ^ ze;
				opLui: res = {instr[15:0], 16'h0000};
				opLw: res = mem[addr[9:2]];
				opLbu: res = {24'h000000, mem[addr[9:2]][8 * addr[1:0] +: 8]};
				opSw: mem[addr[9:2]] = b;
				opSb: mem[addr[9:2]][8 * addr[1:0] +: 8] = b[7:0];
				opBeq: begin
					if (a == b) begin
						nextNpc = pc + 32'd4 + (se << 2);
					end
				end
				opBne: begin
					if (a != b) begin
						nextNpc = pc + 32'd4 + (se << 2);
					end
				end
				opJ: nextNpc = {npc[31:28], instr[25:0], 2'b00};
				opJal: begin
					nextNpc = {npc[31:28], instr[25:0], 2'b00};
					res = pc + 32'd8;
				end
				default: ;
			endcase
			if (dest != 0) begin
				regs[dest] = res;
				expected.push_back('{sect: 3'(sectionOf(pc)), pc: pc,
					num: regAddrT'(dest), data: res});
			end
			pc = npc;
			npc = nextNpc;
			steps++;
		end
	endfunction

	function automatic void countCheck(int sect, bit failed);
		sectChecks[sect]++;
		checkCount++;
		if (failed) begin
			sectErrs[sect]++;
			errorCount++;
		end
	endfunction

	function automatic void reportSections(int upTo);
		while (nextReport < upTo) begin
			$display("%s: %0d checks, %0d errors", sectName[nextReport],
				sectChecks[nextReport], sectErrs[nextReport]);
			nextReport++;
		end
	endfunction

	always @(negedge clk) begin
		wbT head;
		if (!reset && dataSramWen !== 4'b0000) begin
			if (dataSramEn !== 1'b1 || !($onehot(dataSramWen) || dataSramWen == 4'b1111)) begin
				$display("bad data SRAM write: enable %b with request %b", dataSramWen, dataSramEn);
				errorCount++;
			end
		end
		if (!reset && debugWbRfWen !== 4'b0000) begin
			if (expected.size() == 0) begin
				$display("unexpected register write r%0d=%h from pc %h after the program ended",
					debugWbRfWnum, debugWbRfWdata, debugWbPc);
				countCheck(4, 1'b1);
			end else begin
				head = expected.pop_front();
				reportSections(int'(head.sect));
				if (debugWbPc !== head.pc || debugWbRfWnum !== head.num
						|| debugWbRfWdata !== head.data || debugWbRfWen !== 4'b1111) begin
					$display("FAIL %s: expected pc=%h r%0d=%h, actual pc=%h r%0d=%h",
						sectName[head.sect], head.pc, head.num, head.data,
						debugWbPc, debugWbRfWnum, debugWbRfWdata);
					countCheck(int'(head.sect), 1'b1);
				end else begin
					countCheck(int'(head.sect), 1'b0);
				end
			end
		end
	end

	initial begin
		void'($urandom(37));
		progLen = 0;
		checkCount = 0;
		errorCount = 0;
		nextReport = 1;
		for (int i = 0; i < 1024; i++) begin
			imem[i] = '0;
		end
		for (int i = 0; i < 256; i++) begin
			dmem[i] = fillWord(i);
		end
		buildDirected();
		buildRandom();
		runInstrSet();
		programReady = 1'b1;

		// control outputs stay quiet through reset and one cycle after it
		do begin
			@(negedge clk);
			if (instSramEn !== 1'b0 || dataSramEn !== 1'b0 || debugWbRfWen !== 4'b0000) begin
				$display("FAIL reset: expected controls 0 0 0000, actual %b %b %b",
					instSramEn, dataSramEn, debugWbRfWen);
				countCheck(0, 1'b1);
			end else begin
				countCheck(0, 1'b0);
			end
		end while (reset);
		// the first fetch goes out in the cycle after that
		@(negedge clk);
		if (instSramEn !== 1'b1 || instSramAddr !== resetPc) begin
			$display("FAIL reset: expected first fetch 1 %h, actual %b %h",
				resetPc, instSramEn, instSramAddr);
			countCheck(0, 1'b1);
		end else begin
			countCheck(0, 1'b0);
		end
		$display("%s: %0d checks, %0d errors", sectName[0], sectChecks[0], sectErrs[0]);

		while (!(instSramEn === 1'b1 && instSramAddr === finalPc)) begin
			@(negedge clk);
		end
		// let the instructions ahead of the final jump drain
		repeat (12) @(negedge clk);
		reportSections(5);
		if (expected.size() != 0) begin
			$display("%0d expected register writes never appeared, the first from pc %h",
				expected.size(), expected[0].pc);
			errorCount++;
		end
		$display("total: %0d checks, %0d errors", checkCount, errorCount);
		if (errorCount == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

	initial begin
		wait (programReady);
		repeat (10 * progLen + 100) @(posedge clk);
		$display("timeout: the core did not reach the final jump within %0d cycles",
			10 * progLen + 100);
		$display("CHECKS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* vlog.f */
design/mipsPkg.sv
design/regFile.sv
design/hazardUnit.sv
design/fetchStage.sv
design/decodeStage.sv
design/executeStage.sv
design/memoryStage.sv
design/mipsCore.sv
testbench/mipsCoreAssert.sv
testbench/tbMipsCore.sv
